// File: rtl/gpu_pkg.sv
package gpu_pkg;

	typedef logic [4:0] reg_idx_t;
	typedef logic [31:0] word_t;

	// destination of an instruction at one pipeline point
	typedef struct packed
	{
		logic has_writeback;
		reg_idx_t reg_idx;
		logic is_vector;
	} wb_tag_t;

	typedef enum logic [5:0]
	{
		ALU_OR = 6'd0,
		ALU_AND = 6'd1,
		ALU_XOR = 6'd2,
		ALU_ADD = 6'd3,
		ALU_SUB = 6'd4,
		ALU_SHL = 6'd5,
		ALU_SHR = 6'd6,     // logical
		ALU_MOVE = 6'd7,    // copy of operand 2
		ALU_CMP_EQ = 6'd8,
		ALU_CMP_NE = 6'd9,
		ALU_CMP_LT = 6'd10, // signed
		ALU_CMP_GT = 6'd11  // signed
	} alu_op_e;

	typedef enum logic [1:0]
	{
		OP2_SCALAR = 2'd0,
		OP2_VECTOR = 2'd1,
		OP2_IMM = 2'd2
	} op2_src_e;

	typedef enum logic [2:0]
	{
		MASK_S1 = 3'd0,
		MASK_NOT_S1 = 3'd1,
		MASK_S1_ALT = 3'd2,
		MASK_NOT_S1_ALT = 3'd3,
		MASK_ALL = 3'd4
	} mask_src_e;

	// reads as the pc of the instruction
	localparam reg_idx_t PC_REG = 5'd31;

	// instruction[31:30]
	localparam logic [1:0] MEM_CLASS = 2'b10;

	// instruction[28:25], each kind spans KIND_SPAN codes from its first one
	localparam logic [3:0] KIND_BLOCK = 4'd6;
	localparam logic [3:0] KIND_STRIDED = 4'd9;
	localparam logic [3:0] KIND_GATHER = 4'd12;
	localparam logic [3:0] KIND_SPAN = 4'd3;

	// instruction[31:28]
	localparam logic [3:0] BRANCH_CLASS = 4'b1111;

	// instruction[27:26]
	localparam logic [1:0] BR_ALL = 2'd0;
	localparam logic [1:0] BR_ZERO = 2'd1;
	localparam logic [1:0] BR_NOT_ZERO = 2'd2;
	localparam logic [1:0] BR_ALWAYS = 2'd3;

endpackage

// File: rtl/vector_bypass_unit.sv
`timescale 1ns/1ps

module vector_bypass_unit import gpu_pkg::*;
#(
	parameter int NUM_LANES = 16
)
(
	input reg_idx_t sel_i,
	input word_t [NUM_LANES-1:0] data_i,        // register file value
	input wb_tag_t own_tag_i,                   // this stage's result
	input word_t [NUM_LANES-1:0] own_value_i,
	input logic [NUM_LANES-1:0] own_mask_i,
	input wb_tag_t mem_tag_i,                   // memory access stage
	input word_t [NUM_LANES-1:0] mem_value_i,
	input logic [NUM_LANES-1:0] mem_mask_i,
	input wb_tag_t wb_tag_i,                    // writeback stage
	input word_t [NUM_LANES-1:0] wb_value_i,
	input logic [NUM_LANES-1:0] wb_mask_i,
	output word_t [NUM_LANES-1:0] value_o
);

	logic own_hit;
	logic mem_hit;
	logic wb_hit;

	function automatic logic vector_hit(input wb_tag_t tag, input reg_idx_t sel);
		return tag.has_writeback && tag.is_vector && (tag.reg_idx == sel);
	endfunction

	assign own_hit = vector_hit(own_tag_i, sel_i);
	assign mem_hit = vector_hit(mem_tag_i, sel_i);
	assign wb_hit = vector_hit(wb_tag_i, sel_i);

	// lanes a newer write masked off fall through to the older sources
	always_comb
	begin
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			if (own_hit && own_mask_i[lane])
				value_o[lane] = own_value_i[lane];
			else if (mem_hit && mem_mask_i[lane])
				value_o[lane] = mem_value_i[lane];
			else if (wb_hit && wb_mask_i[lane])
				value_o[lane] = wb_value_i[lane];
			else
				value_o[lane] = data_i[lane];
		end
	end

endmodule

// File: rtl/lane_alu.sv
`timescale 1ns/1ps

module lane_alu import gpu_pkg::*;
#(
	parameter int NUM_LANES = 16
)
(
	input alu_op_e op_i,
	input word_t [NUM_LANES-1:0] operand1_i,
	input word_t [NUM_LANES-1:0] operand2_i,
	output word_t [NUM_LANES-1:0] result_o
);

	logic [NUM_LANES-1:0] cmp_bits;
	logic is_compare;

	assign is_compare = op_i inside {ALU_CMP_EQ, ALU_CMP_NE, ALU_CMP_LT, ALU_CMP_GT};

	always_comb
	begin
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			case (op_i)
				ALU_CMP_EQ:
					cmp_bits[lane] = operand1_i[lane] == operand2_i[lane];
				ALU_CMP_NE:
					cmp_bits[lane] = operand1_i[lane] != operand2_i[lane];
				ALU_CMP_LT:
					cmp_bits[lane] = signed'(operand1_i[lane]) < signed'(operand2_i[lane]);
				ALU_CMP_GT:
					cmp_bits[lane] = signed'(operand1_i[lane]) > signed'(operand2_i[lane]);
				default:
					cmp_bits[lane] = 1'b0;
			endcase
		end
	end

	always_comb
	begin
		result_o = '0;
		if (is_compare)
		begin
			result_o[0] = word_t'(cmp_bits); // one bit per lane, packed into lane 0
		end
		else
		begin
			for (int lane = 0; lane < NUM_LANES; lane++)
			begin
				case (op_i)
					ALU_OR:
						result_o[lane] = operand1_i[lane] | operand2_i[lane];
					ALU_AND:
						result_o[lane] = operand1_i[lane] & operand2_i[lane];
					ALU_XOR:
						result_o[lane] = operand1_i[lane] ^ operand2_i[lane];
					ALU_ADD:
						result_o[lane] = operand1_i[lane] + operand2_i[lane];
					ALU_SUB:
						result_o[lane] = operand1_i[lane] - operand2_i[lane];
					ALU_SHL:
						result_o[lane] = operand1_i[lane] << operand2_i[lane][4:0];
					ALU_SHR:
						result_o[lane] = operand1_i[lane] >> operand2_i[lane][4:0];
					ALU_MOVE:
						result_o[lane] = operand2_i[lane];
					default:
						result_o[lane] = '0;
				endcase
			end
		end

		if (!$isunknown(op_i))
		begin
			assert (op_i inside {ALU_OR, ALU_AND, ALU_XOR, ALU_ADD, ALU_SUB, ALU_SHL,
				ALU_SHR, ALU_MOVE, ALU_CMP_EQ, ALU_CMP_NE, ALU_CMP_LT, ALU_CMP_GT})
			else
				$error("lane_alu: undefined opcode %0d", op_i);
		end
	end

endmodule

// File: rtl/mem_address_gen.sv
`timescale 1ns/1ps

module mem_address_gen import gpu_pkg::*;
#(
	parameter int NUM_LANES = 16,
	localparam int LANE_W = $clog2(NUM_LANES)
)
(
	input word_t instruction_i,
	input word_t [NUM_LANES-1:0] alu_result_i,
	input word_t immediate_i,
	input logic [LANE_W-1:0] lane_select_i,
	input logic [NUM_LANES-1:0] lane_mask_i,
	output word_t daddress_o,
	output logic daccess_o
);

	logic [3:0] kind;
	word_t lane_offset;

	assign kind = instruction_i[28:25];
	assign lane_offset = word_t'(lane_select_i);

	always_comb
	begin
		if (kind >= KIND_BLOCK && kind < KIND_BLOCK + KIND_SPAN)
			daddress_o = alu_result_i[0] + (lane_offset << 2);
		else if (kind >= KIND_STRIDED && kind < KIND_STRIDED + KIND_SPAN)
			daddress_o = alu_result_i[0] + lane_offset * immediate_i;
		else if (kind >= KIND_GATHER && kind < KIND_GATHER + KIND_SPAN)
			daddress_o = alu_result_i[lane_select_i]; // per-lane pointer
		else
			daddress_o = alu_result_i[0];
	end

	// masked-off lanes issue no access
	assign daccess_o = (instruction_i[31:30] == MEM_CLASS) && lane_mask_i[lane_select_i];

endmodule

// File: rtl/branch_unit.sv
`timescale 1ns/1ps

module branch_unit import gpu_pkg::*;
(
	input word_t instruction_i,
	input word_t pc_i,
	input logic [15:0] cond_bits_i,
	output logic rollback_request_o,
	output word_t rollback_address_o
);

	logic is_branch;
	logic taken;
	word_t offset;

	assign is_branch = instruction_i[31:28] == BRANCH_CLASS;
	assign offset = {{11{instruction_i[25]}}, instruction_i[25:5]};

	always_comb
	begin
		case (instruction_i[27:26])
			BR_ALL:
				taken = cond_bits_i == 16'hffff;
			BR_ZERO:
				taken = cond_bits_i == 16'h0000;
			BR_NOT_ZERO:
				taken = cond_bits_i != 16'h0000;
			BR_ALWAYS:
				taken = 1'b1;
			default:
				taken = 1'b0;
		endcase
	end

	assign rollback_request_o = is_branch && taken;
	assign rollback_address_o = is_branch ? pc_i + offset : '0;

endmodule

// File: rtl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage import gpu_pkg::*;
#(
	parameter int NUM_LANES = 16,
	localparam int LANE_W = $clog2(NUM_LANES)
)
(
	input logic clk,
	input logic rst_n_i,
	input logic flush_i,
	input word_t instruction_i,
	input word_t pc_i,
	input word_t immediate_i,
	input word_t scalar_value1_i,
	input reg_idx_t scalar_sel1_i,
	input word_t scalar_value2_i,
	input reg_idx_t scalar_sel2_i,
	input word_t [NUM_LANES-1:0] vector_value1_i,
	input reg_idx_t vector_sel1_i,
	input word_t [NUM_LANES-1:0] vector_value2_i,
	input reg_idx_t vector_sel2_i,
	input logic op1_is_vector_i,
	input op2_src_e op2_src_i,
	input mask_src_e mask_src_i,
	input logic store_value_is_vector_i,
	input alu_op_e alu_op_i,
	input logic [LANE_W-1:0] lane_select_i,
	input wb_tag_t writeback_i,
	input wb_tag_t bypass1_tag_i,                    // memory access stage
	input word_t [NUM_LANES-1:0] bypass1_value_i,
	input logic [NUM_LANES-1:0] bypass1_mask_i,
	input wb_tag_t bypass2_tag_i,                    // writeback stage
	input word_t [NUM_LANES-1:0] bypass2_value_i,
	input logic [NUM_LANES-1:0] bypass2_mask_i,
	output word_t instruction_o,
	output word_t pc_o,
	output wb_tag_t writeback_o,
	output word_t [NUM_LANES-1:0] result_o,
	output logic [NUM_LANES-1:0] mask_o,
	output word_t store_value_o,
	output logic [LANE_W-1:0] lane_select_o,
	output word_t daddress_o,
	output logic daccess_o,
	output logic rollback_request_o,
	output word_t rollback_address_o
);

	reg_idx_t scalar_sel [2];
	word_t scalar_file [2];
	word_t scalar_fwd [2];
	word_t [NUM_LANES-1:0] vector_fwd1;
	word_t [NUM_LANES-1:0] vector_fwd2;
	word_t [NUM_LANES-1:0] op1;
	word_t [NUM_LANES-1:0] op2;
	word_t [NUM_LANES-1:0] alu_result;
	logic [NUM_LANES-1:0] mask_nxt;
	word_t store_value_nxt;

	function automatic logic scalar_hit(input wb_tag_t tag, input reg_idx_t sel);
		return tag.has_writeback && !tag.is_vector && (tag.reg_idx == sel);
	endfunction

	assign scalar_sel[0] = scalar_sel1_i;
	assign scalar_sel[1] = scalar_sel2_i;
	assign scalar_file[0] = scalar_value1_i;
	assign scalar_file[1] = scalar_value2_i;

	// newest producer wins and scalars sit in lane 0
	always_comb
	begin
		for (int i = 0; i < 2; i++)
		begin
			if (scalar_sel[i] == PC_REG)
				scalar_fwd[i] = pc_i;
			else if (scalar_hit(writeback_o, scalar_sel[i]))
				scalar_fwd[i] = result_o[0];
			else if (scalar_hit(bypass1_tag_i, scalar_sel[i]))
				scalar_fwd[i] = bypass1_value_i[0];
			else if (scalar_hit(bypass2_tag_i, scalar_sel[i]))
				scalar_fwd[i] = bypass2_value_i[0];
			else
				scalar_fwd[i] = scalar_file[i];
		end
	end

	vector_bypass_unit #(.NUM_LANES(NUM_LANES)) u_vbu1
	(
		.sel_i(vector_sel1_i),
		.data_i(vector_value1_i),
		.own_tag_i(writeback_o),
		.own_value_i(result_o),
		.own_mask_i(mask_o),
		.mem_tag_i(bypass1_tag_i),
		.mem_value_i(bypass1_value_i),
		.mem_mask_i(bypass1_mask_i),
		.wb_tag_i(bypass2_tag_i),
		.wb_value_i(bypass2_value_i),
		.wb_mask_i(bypass2_mask_i),
		.value_o(vector_fwd1)
	);

	vector_bypass_unit #(.NUM_LANES(NUM_LANES)) u_vbu2
	(
		.sel_i(vector_sel2_i),
		.data_i(vector_value2_i),
		.own_tag_i(writeback_o),
		.own_value_i(result_o),
		.own_mask_i(mask_o),
		.mem_tag_i(bypass1_tag_i),
		.mem_value_i(bypass1_value_i),
		.mem_mask_i(bypass1_mask_i),
		.wb_tag_i(bypass2_tag_i),
		.wb_value_i(bypass2_value_i),
		.wb_mask_i(bypass2_mask_i),
		.value_o(vector_fwd2)
	);

	assign op1 = op1_is_vector_i ? vector_fwd1 : {NUM_LANES{scalar_fwd[0]}};

	always_comb
	begin
		case (op2_src_i)
			OP2_SCALAR: op2 = {NUM_LANES{scalar_fwd[1]}};
			OP2_VECTOR: op2 = vector_fwd2;
			OP2_IMM: op2 = {NUM_LANES{immediate_i}};
			default: op2 = '0;
		endcase
	end

	always_comb
	begin
		case (mask_src_i)
			MASK_S1, MASK_S1_ALT: mask_nxt = scalar_fwd[0][NUM_LANES-1:0];
			MASK_NOT_S1, MASK_NOT_S1_ALT: mask_nxt = ~scalar_fwd[0][NUM_LANES-1:0];
			MASK_ALL: mask_nxt = '1;
			default: mask_nxt = '0;
		endcase
	end

	assign store_value_nxt = store_value_is_vector_i ? vector_fwd2[lane_select_i] : scalar_fwd[1];

	lane_alu #(.NUM_LANES(NUM_LANES)) u_lane_alu
	(
		.op_i(alu_op_i),
		.operand1_i(op1),
		.operand2_i(op2),
		.result_o(alu_result)
	);

	// memory request leaves unregistered in this cycle
	mem_address_gen #(.NUM_LANES(NUM_LANES)) u_mem_address_gen
	(
		.instruction_i(instruction_i),
		.alu_result_i(alu_result),
		.immediate_i(immediate_i),
		.lane_select_i(lane_select_i),
		.lane_mask_i(mask_nxt),
		.daddress_o(daddress_o),
		.daccess_o(daccess_o)
	);

	branch_unit u_branch_unit
	(
		.instruction_i(instruction_i),
		.pc_i(pc_i),
		.cond_bits_i(alu_result[0][15:0]),
		.rollback_request_o(rollback_request_o),
		.rollback_address_o(rollback_address_o)
	);

	always_ff @(posedge clk or negedge rst_n_i)
	begin
		if (!rst_n_i)
		begin
			instruction_o <= '0;
			pc_o <= '0;
			writeback_o <= '0;
			result_o <= '0;
			mask_o <= '0;
			store_value_o <= '0;
			lane_select_o <= '0;
		end
		else if (flush_i)
		begin
			instruction_o <= '0;
			pc_o <= '0;
			writeback_o <= '0;
			result_o <= '0;
			mask_o <= '0;
			store_value_o <= '0;
			lane_select_o <= '0;
		end
		else
		begin
			instruction_o <= instruction_i;
			pc_o <= pc_i;
			writeback_o <= writeback_i;
			result_o <= alu_result;
			mask_o <= mask_nxt;
			store_value_o <= store_value_nxt;
			lane_select_o <= lane_select_i;
		end
	end

	op2_src_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
		op2_src_i inside {OP2_SCALAR, OP2_VECTOR, OP2_IMM})
	else
		$error("execute_stage: illegal op2 source %0d", op2_src_i);

	mask_src_legal: assert property (@(posedge clk) disable iff (!rst_n_i)
		mask_src_i inside {MASK_S1, MASK_NOT_S1, MASK_S1_ALT, MASK_NOT_S1_ALT, MASK_ALL})
	else
		$error("execute_stage: illegal mask source %0d", mask_src_i);

endmodule

// File: dv/tb_execute_stage.sv
`timescale 1ns/1ps

module tb_execute_stage import gpu_pkg::*;
();

	localparam int NUM_LANES = 16;
	localparam int LANE_W = $clog2(NUM_LANES);
	localparam int VEC_W = NUM_LANES * 32;
	localparam int PERIOD = 100;
	localparam int NUM_CYCLES = 2000;

	typedef word_t [NUM_LANES-1:0] vec_t;

	logic clk;
	logic rst_n_i;
	logic flush_i;
	word_t instruction_i;
	word_t pc_i;
	word_t immediate_i;
	word_t scalar_value1_i;
	reg_idx_t scalar_sel1_i;
	word_t scalar_value2_i;
	reg_idx_t scalar_sel2_i;
	vec_t vector_value1_i;
	reg_idx_t vector_sel1_i;
	vec_t vector_value2_i;
	reg_idx_t vector_sel2_i;
	logic op1_is_vector_i;
	op2_src_e op2_src_i;
	mask_src_e mask_src_i;
	logic store_value_is_vector_i;
	alu_op_e alu_op_i;
	logic [LANE_W-1:0] lane_select_i;
	wb_tag_t writeback_i;
	wb_tag_t bypass1_tag_i;
	vec_t bypass1_value_i;
	logic [NUM_LANES-1:0] bypass1_mask_i;
	wb_tag_t bypass2_tag_i;
	vec_t bypass2_value_i;
	logic [NUM_LANES-1:0] bypass2_mask_i;
	word_t instruction_o;
	word_t pc_o;
	wb_tag_t writeback_o;
	vec_t result_o;
	logic [NUM_LANES-1:0] mask_o;
	word_t store_value_o;
	logic [LANE_W-1:0] lane_select_o;
	word_t daddress_o;
	logic daccess_o;
	logic rollback_request_o;
	word_t rollback_address_o;

	// model copy of the stage register
	// m_ is the current value and n_ the value after the next edge
	word_t m_instruction, n_instruction;
	word_t m_pc, n_pc;
	wb_tag_t m_writeback, n_writeback;
	vec_t m_result, n_result;
	logic [NUM_LANES-1:0] m_mask, n_mask;
	word_t m_store, n_store;
	logic [LANE_W-1:0] m_lane_select, n_lane_select;

	word_t exp_daddress;
	logic exp_daccess;
	logic exp_rollback;
	word_t exp_target;

	int seed = 32'h41f575e1;

	execute_stage #(.NUM_LANES(NUM_LANES)) u_execute_stage (.*);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#((NUM_CYCLES + 100) * PERIOD);
		$display("timeout: the run did not finish within %0d clock periods", NUM_CYCLES + 100);
		$display("test failed");
		$fatal(1);
	end

	task automatic check_value(input logic [VEC_W-1:0] actual, input logic [VEC_W-1:0] expected,
		input string what);
		if (actual !== expected)
		begin
			$display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
			$display("test failed");
			$fatal(1);
		end
	endtask

	function automatic word_t draw_word();
		return $random(seed);
	endfunction

	function automatic int below(input int n);
		word_t w;
		w = draw_word();
		return int'(w % word_t'(n));
	endfunction

	// biased so compares and branch conditions hit
	function automatic word_t operand_value();
		word_t w;
		w = draw_word();
		case (w[31:29])
			3'd0, 3'd1: return {28'h0, w[3:0]};
			3'd2: return 32'hffff_ffff;
			default: return w;
		endcase
	endfunction

	function automatic reg_idx_t register_selector();
		word_t w;
		w = draw_word();
		if (w[7:4] == 4'h0)
			return PC_REG;
		return {3'b000, w[1:0]}; // small range for frequent hits
	endfunction

	function automatic wb_tag_t writeback_tag();
		word_t w;
		wb_tag_t t;
		w = draw_word();
		t.has_writeback = w[0] | w[1];
		t.reg_idx = (w[7:5] == 3'd0) ? PC_REG : {3'b000, w[3:2]}; // pc register now and then
		t.is_vector = w[4];
		return t;
	endfunction

	function automatic vec_t lane_values();
		vec_t v;
		for (int lane = 0; lane < NUM_LANES; lane++)
			v[lane] = operand_value();
		return v;
	endfunction

	function automatic word_t instruction_word();
		word_t w;
		w = draw_word();
		case (below(4))
			0: w[31:30] = MEM_CLASS;
			1: w[31:28] = BRANCH_CLASS;
			default: ;
		endcase
		return w;
	endfunction

	task automatic drive_inputs();
		flush_i <= (below(16) == 0);
		instruction_i <= instruction_word();
		pc_i <= draw_word();
		immediate_i <= operand_value();
		scalar_value1_i <= operand_value();
		scalar_sel1_i <= register_selector();
		scalar_value2_i <= operand_value();
		scalar_sel2_i <= register_selector();
		vector_value1_i <= lane_values();
		vector_sel1_i <= register_selector();
		vector_value2_i <= lane_values();
		vector_sel2_i <= register_selector();
		op1_is_vector_i <= (below(2) == 1);
		op2_src_i <= op2_src_e'(below(3));
		mask_src_i <= mask_src_e'(below(5));
		store_value_is_vector_i <= (below(2) == 1);
		alu_op_i <= alu_op_e'(below(12));
		lane_select_i <= LANE_W'(below(NUM_LANES));
		writeback_i <= writeback_tag();
		bypass1_tag_i <= writeback_tag();
		bypass1_value_i <= lane_values();
		bypass1_mask_i <= NUM_LANES'(draw_word());
		bypass2_tag_i <= writeback_tag();
		bypass2_value_i <= lane_values();
		bypass2_mask_i <= NUM_LANES'(draw_word());
	endtask

	function automatic logic tag_matches(input wb_tag_t tag, input reg_idx_t sel, input logic vec);
		return tag.has_writeback && tag.reg_idx == sel && tag.is_vector == vec;
	endfunction

	function automatic word_t forward_scalar(input reg_idx_t sel, input word_t file_value);
		if (sel == PC_REG)
			return pc_i;
		if (tag_matches(m_writeback, sel, 1'b0))
			return m_result[0];
		if (tag_matches(bypass1_tag_i, sel, 1'b0))
			return bypass1_value_i[0];
		if (tag_matches(bypass2_tag_i, sel, 1'b0))
			return bypass2_value_i[0];
		return file_value;
	endfunction

	// oldest source first so newer ones overwrite
	function automatic vec_t forward_vector(input reg_idx_t sel, input vec_t file_value);
		vec_t v;
		v = file_value;
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			if (tag_matches(bypass2_tag_i, sel, 1'b1) && bypass2_mask_i[lane])
				v[lane] = bypass2_value_i[lane];
			if (tag_matches(bypass1_tag_i, sel, 1'b1) && bypass1_mask_i[lane])
				v[lane] = bypass1_value_i[lane];
			if (tag_matches(m_writeback, sel, 1'b1) && m_mask[lane])
				v[lane] = m_result[lane];
		end
		return v;
	endfunction

	function automatic vec_t alu_reference(input alu_op_e op, input vec_t a, input vec_t b);
		vec_t r;
		r = '0;
		for (int lane = 0; lane < NUM_LANES; lane++)
		begin
			case (op)
				ALU_OR: r[lane] = a[lane] | b[lane];
				ALU_AND: r[lane] = a[lane] & b[lane];
				ALU_XOR: r[lane] = a[lane] ^ b[lane];
				ALU_ADD: r[lane] = a[lane] + b[lane];
				ALU_SUB: r[lane] = a[lane] - b[lane];
				ALU_SHL: r[lane] = a[lane] << b[lane][4:0];
				ALU_SHR: r[lane] = a[lane] >> b[lane][4:0];
				ALU_MOVE: r[lane] = b[lane];
				ALU_CMP_EQ: r[0][lane] = a[lane] == b[lane]; // mask bits in lane 0
				ALU_CMP_NE: r[0][lane] = a[lane] != b[lane];
				ALU_CMP_LT: r[0][lane] = $signed(a[lane]) < $signed(b[lane]);
				ALU_CMP_GT: r[0][lane] = $signed(a[lane]) > $signed(b[lane]);
				default: r[lane] = '0;
			endcase
		end
		return r;
	endfunction

	task automatic compute_expected();
		word_t s1;
		word_t s2;
		vec_t v1;
		vec_t v2;
		vec_t a;
		vec_t b;
		vec_t res;
		logic [NUM_LANES-1:0] mask;
		logic [3:0] kind;
		word_t lane_index;

		s1 = forward_scalar(scalar_sel1_i, scalar_value1_i);
		s2 = forward_scalar(scalar_sel2_i, scalar_value2_i);
		v1 = forward_vector(vector_sel1_i, vector_value1_i);
		v2 = forward_vector(vector_sel2_i, vector_value2_i);
		a = op1_is_vector_i ? v1 : {NUM_LANES{s1}};
		case (op2_src_i)
			OP2_VECTOR: b = v2;
			OP2_IMM: b = {NUM_LANES{immediate_i}};
			default: b = {NUM_LANES{s2}};
		endcase
		res = alu_reference(alu_op_i, a, b);
		case (mask_src_i)
			MASK_S1, MASK_S1_ALT: mask = s1[NUM_LANES-1:0];
			MASK_NOT_S1, MASK_NOT_S1_ALT: mask = ~s1[NUM_LANES-1:0];
			default: mask = '1;
		endcase

		kind = instruction_i[28:25];
		lane_index = {{(32 - LANE_W){1'b0}}, lane_select_i};
		if (kind >= 4'd6 && kind <= 4'd8)
			exp_daddress = res[0] + lane_index * 4;
		else if (kind >= 4'd9 && kind <= 4'd11)
			exp_daddress = res[0] + lane_index * immediate_i;
		else if (kind >= 4'd12 && kind <= 4'd14)
			exp_daddress = res[lane_select_i];
		else
			exp_daddress = res[0];
		exp_daccess = instruction_i[31:30] == MEM_CLASS && mask[lane_select_i];

		exp_rollback = 1'b0;
		exp_target = '0;
		if (instruction_i[31:28] == BRANCH_CLASS)
		begin
			exp_target = pc_i + {{11{instruction_i[25]}}, instruction_i[25:5]};
			case (instruction_i[27:26])
				BR_ALL: exp_rollback = res[0][15:0] == 16'hffff;
				BR_ZERO: exp_rollback = res[0][15:0] == 16'h0000;
				BR_NOT_ZERO: exp_rollback = res[0][15:0] != 16'h0000;
				default: exp_rollback = 1'b1;
			endcase
		end

		n_instruction = flush_i ? '0 : instruction_i;
		n_pc = flush_i ? '0 : pc_i;
		n_writeback = flush_i ? '0 : writeback_i;
		n_result = flush_i ? '0 : res;
		n_mask = flush_i ? '0 : mask;
		n_store = flush_i ? '0 : (store_value_is_vector_i ? v2[lane_select_i] : s2);
		n_lane_select = flush_i ? '0 : lane_select_i;
	endtask

	initial
	begin
		rst_n_i = 1'b0;
		flush_i = 1'b0;
		instruction_i = '0;
		pc_i = '0;
		immediate_i = '0;
		scalar_value1_i = '0;
		scalar_sel1_i = '0;
		scalar_value2_i = '0;
		scalar_sel2_i = '0;
		vector_value1_i = '0;
		vector_sel1_i = '0;
		vector_value2_i = '0;
		vector_sel2_i = '0;
		op1_is_vector_i = 1'b0;
		op2_src_i = OP2_SCALAR;
		mask_src_i = MASK_ALL;
		store_value_is_vector_i = 1'b0;
		alu_op_i = ALU_OR;
		lane_select_i = '0;
		writeback_i = '0;
		bypass1_tag_i = '0;
		bypass1_value_i = '0;
		bypass1_mask_i = '0;
		bypass2_tag_i = '0;
		bypass2_value_i = '0;
		bypass2_mask_i = '0;
		{n_instruction, n_pc, n_writeback, n_result, n_mask, n_store, n_lane_select} = '0;

		repeat (2) @(posedge clk);
		rst_n_i <= 1'b1;
		for (int cycle = 0; cycle < NUM_CYCLES; cycle++)
		begin
			@(negedge clk);
			m_instruction = n_instruction;
			m_pc = n_pc;
			m_writeback = n_writeback;
			m_result = n_result;
			m_mask = n_mask;
			m_store = n_store;
			m_lane_select = n_lane_select;
			check_value(VEC_W'(instruction_o), VEC_W'(m_instruction), "instruction_o");
			check_value(VEC_W'(pc_o), VEC_W'(m_pc), "pc_o");
			check_value(VEC_W'(writeback_o), VEC_W'(m_writeback), "writeback_o");
			check_value(result_o, m_result, "result_o");
			check_value(VEC_W'(mask_o), VEC_W'(m_mask), "mask_o");
			check_value(VEC_W'(store_value_o), VEC_W'(m_store), "store_value_o");
			check_value(VEC_W'(lane_select_o), VEC_W'(m_lane_select), "lane_select_o");

			compute_expected(); // same-cycle outputs
			check_value(VEC_W'(daddress_o), VEC_W'(exp_daddress), "daddress_o");
			check_value(VEC_W'(daccess_o), VEC_W'(exp_daccess), "daccess_o");
			check_value(VEC_W'(rollback_request_o), VEC_W'(exp_rollback), "rollback_request_o");
			check_value(VEC_W'(rollback_address_o), VEC_W'(exp_target), "rollback_address_o");

			@(posedge clk);
			drive_inputs();
		end
		$display("test passed");
		$finish;
	end

endmodule

// File: list.f
rtl/gpu_pkg.sv
rtl/vector_bypass_unit.sv
rtl/lane_alu.sv
rtl/mem_address_gen.sv
rtl/branch_unit.sv
rtl/execute_stage.sv
dv/tb_execute_stage.sv

// File: run.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
	--top-module tb_execute_stage \
	-f list.f \
	-o sim_execute_stage

# the simulator exit status is masked by tee, the log decides
./obj_dir/sim_execute_stage | tee sim.log

if grep -qx "test passed" sim.log
then
	echo "simulation PASSED"
else
	echo "simulation FAILED, see sim.log"
	exit 1
fi
